// File: source/lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// width of a data word and of an address
`define LC3B_WORD_W 16

// general purpose registers r0 to r7
`define LC3B_NUM_REGS 8

// first fetch address after reset
`define LC3B_RESET_PC 0

// the opcode sits in the top nibble of every instruction
`define LC3B_OPCODE_MSB 15
`define LC3B_OPCODE_LSB 12

`endif

// File: source/lc3b_types.sv
`include "lc3b_cfg.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [$clog2(`LC3B_NUM_REGS)-1:0] lc3b_reg;

    // n, z, p from msb to lsb
    typedef logic [2:0] lc3b_cc;

    // encodings follow the lc-3b opcode map
    typedef enum logic [`LC3B_OPCODE_MSB-`LC3B_OPCODE_LSB:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not
    } lc3b_alu_op;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_alu_op alu_op;
        logic       use_imm;
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        lc3b_reg    dest;
        lc3b_cc     nzp;
    } lc3b_control_word;

    typedef struct packed {
        logic     valid;
        lc3b_word ir;
        lc3b_word pc_plus2;
    } if_id_t;

    typedef struct packed {
        logic             valid;
        lc3b_control_word control;
        lc3b_word         pc_plus2;
        lc3b_word         sr1;
        lc3b_word         sr2;
        lc3b_word         imm;
        lc3b_word         offset;
    } id_ex_t;

    typedef struct packed {
        logic             valid;
        lc3b_control_word control;
        lc3b_word         alu;
        lc3b_word         addr;
        lc3b_word         store_data;
        lc3b_word         branch_target;
    } ex_mem_t;

    // register file write port
    typedef struct packed {
        logic     load;
        lc3b_reg  dest;
        lc3b_word data;
    } wb_t;

endpackage : lc3b_types

// File: source/stage_if.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module stage_if (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_hold,
    input  logic                 decode_hold,
    input  logic                 redirect,
    input  lc3b_types::lc3b_word redirect_pc,
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_data,
    output lc3b_types::if_id_t   if_out
);

    lc3b_types::lc3b_word pc;
    lc3b_types::lc3b_word pc_plus2;

    assign imem_addr = pc;
    assign pc_plus2  = pc + lc3b_types::lc3b_word'(2);

    // taken branch beats any hold
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= lc3b_types::lc3b_word'(`LC3B_RESET_PC);
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (!fetch_hold) begin
            pc <= pc_plus2;
        end
    end

    // fetch output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_out.valid <= 1'b0;
        end else if (decode_hold) begin
            // decode is stuck, keep the same entry
            if_out <= if_out;
        end else if (fetch_hold) begin
            if_out.valid <= 1'b0;
        end else begin
            if_out.valid    <= 1'b1;
            if_out.ir       <= imem_data;
            if_out.pc_plus2 <= pc_plus2;
        end
    end

endmodule : stage_if

// File: source/stage_id.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module stage_id (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               decode_hold,
    input  lc3b_types::if_id_t id_in,
    input  lc3b_types::wb_t    wb_in,
    output lc3b_types::id_ex_t id_out
);

    lc3b_types::lc3b_word         regs [`LC3B_NUM_REGS];
    lc3b_types::lc3b_opcode       opcode;
    lc3b_types::lc3b_control_word ctrl;
    lc3b_types::lc3b_reg          sr1_idx;
    lc3b_types::lc3b_reg          sr2_idx;
    lc3b_types::lc3b_word         imm5;
    lc3b_types::lc3b_word         offset;

    assign opcode = lc3b_types::lc3b_opcode'(id_in.ir[`LC3B_OPCODE_MSB:`LC3B_OPCODE_LSB]);

    // sr1 doubles as the base register for ldr and str
    assign sr1_idx = id_in.ir[8:6];
    // str reads its source through the second port
    assign sr2_idx = (opcode == lc3b_types::op_str) ? id_in.ir[11:9] : id_in.ir[2:0];

    assign imm5 = lc3b_types::lc3b_word'($signed(id_in.ir[4:0]));

    // br carries offset9, memory ops carry offset6
    always_comb begin
        if (opcode == lc3b_types::op_br) begin
            offset = lc3b_types::lc3b_word'($signed(id_in.ir[8:0]));
        end else begin
            offset = lc3b_types::lc3b_word'($signed(id_in.ir[5:0]));
        end
    end

    // instruction decoder
    always_comb begin
        ctrl         = '0;
        ctrl.opcode  = opcode;
        ctrl.alu_op  = lc3b_types::alu_add;
        ctrl.dest    = id_in.ir[11:9];
        ctrl.nzp     = id_in.ir[11:9];
        case (opcode)
            lc3b_types::op_add: begin
                ctrl.use_imm   = id_in.ir[5];
                ctrl.reg_write = 1'b1;
            end
            lc3b_types::op_and: begin
                ctrl.alu_op    = lc3b_types::alu_and;
                ctrl.use_imm   = id_in.ir[5];
                ctrl.reg_write = 1'b1;
            end
            lc3b_types::op_not: begin
                ctrl.alu_op    = lc3b_types::alu_not;
                ctrl.reg_write = 1'b1;
            end
            lc3b_types::op_ldr: begin
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            lc3b_types::op_str: begin
                ctrl.mem_write = 1'b1;
            end
            lc3b_types::op_br: begin
                ctrl.is_branch = 1'b1;
            end
            // anything outside the subset behaves as a nop
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

    // register file, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_in.load) begin
            regs[wb_in.dest] <= wb_in.data;
        end
    end

    // decode output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_out.valid <= 1'b0;
        end else if (decode_hold || !id_in.valid) begin
            id_out.valid <= 1'b0;
        end else begin
            id_out.valid    <= 1'b1;
            id_out.control  <= ctrl;
            id_out.pc_plus2 <= id_in.pc_plus2;
            id_out.sr1      <= regs[sr1_idx];
            id_out.sr2      <= regs[sr2_idx];
            id_out.imm      <= imm5;
            id_out.offset   <= offset;
        end
    end

endmodule : stage_id

// File: source/stage_ex.sv
`timescale 1ns/1ps

module stage_ex (
    input  logic                clk,
    input  logic                rst_n,
    input  lc3b_types::id_ex_t  ex_in,
    output lc3b_types::ex_mem_t ex_out
);

    lc3b_types::lc3b_word operand_b;
    lc3b_types::lc3b_word alu;
    lc3b_types::lc3b_word addr;
    lc3b_types::lc3b_word target;

    assign operand_b = ex_in.control.use_imm ? ex_in.imm : ex_in.sr2;

    always_comb begin
        case (ex_in.control.alu_op)
            lc3b_types::alu_and: alu = ex_in.sr1 & operand_b;
            lc3b_types::alu_not: alu = ~ex_in.sr1;
            default:             alu = ex_in.sr1 + operand_b;
        endcase
    end

    // offsets count words, so scale to bytes
    assign addr   = ex_in.sr1 + (ex_in.offset << 1);
    assign target = ex_in.pc_plus2 + (ex_in.offset << 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_out.valid <= 1'b0;
        end else begin
            ex_out.valid         <= ex_in.valid;
            ex_out.control       <= ex_in.control;
            ex_out.alu           <= alu;
            ex_out.addr          <= addr;
            ex_out.store_data    <= ex_in.sr2;
            ex_out.branch_target <= target;
        end
    end

endmodule : stage_ex

// File: source/stage_mem.sv
`timescale 1ns/1ps

module stage_mem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lc3b_types::ex_mem_t  mem_in,
    output lc3b_types::lc3b_word dmem_addr,
    output lc3b_types::lc3b_word dmem_wdata,
    output logic                 dmem_we,
    input  lc3b_types::lc3b_word dmem_rdata,
    output logic                 redirect,
    output lc3b_types::lc3b_word redirect_pc,
    output lc3b_types::wb_t      wb_out
);

    lc3b_types::lc3b_cc cc;
    lc3b_types::lc3b_cc cc_next;

    // data port
    assign dmem_addr  = mem_in.addr;
    assign dmem_wdata = mem_in.store_data;
    assign dmem_we    = mem_in.valid & mem_in.control.mem_write;

    // writeback, loads take the memory word
    assign wb_out.load = mem_in.valid & mem_in.control.reg_write;
    assign wb_out.dest = mem_in.control.dest;
    assign wb_out.data = mem_in.control.mem_read ? dmem_rdata : mem_in.alu;

    always_comb begin
        if (wb_out.data[$high(wb_out.data)]) begin
            cc_next = 3'b100;
        end else if (wb_out.data == '0) begin
            cc_next = 3'b010;
        end else begin
            cc_next = 3'b001;
        end
    end

    // condition codes start at z
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc <= 3'b010;
        end else if (wb_out.load) begin
            cc <= cc_next;
        end
    end

    // branch resolution against the committed codes
    assign redirect    = mem_in.valid & mem_in.control.is_branch & |(mem_in.control.nzp & cc);
    assign redirect_pc = mem_in.branch_target;

endmodule : stage_mem

// File: source/hazard_controller.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module hazard_controller (
    input  lc3b_types::if_id_t  id_in,
    input  lc3b_types::id_ex_t  ex_in,
    input  lc3b_types::ex_mem_t mem_in,
    output logic                fetch_hold,
    output logic                decode_hold
);

    lc3b_types::lc3b_opcode opcode;
    lc3b_types::lc3b_reg    src_a;
    lc3b_types::lc3b_reg    src_b;
    logic                   use_a;
    logic                   use_b;
    logic                   ex_wr;
    logic                   mem_wr;
    logic                   branch_in_flight;

    function automatic logic clash(input logic used, input lc3b_types::lc3b_reg src,
                                   input logic wr, input lc3b_types::lc3b_reg dest);
        return used & wr & (src == dest);
    endfunction

    assign opcode = lc3b_types::lc3b_opcode'(id_in.ir[`LC3B_OPCODE_MSB:`LC3B_OPCODE_LSB]);

    // sources that each opcode really reads
    always_comb begin
        use_a = 1'b0;
        use_b = 1'b0;
        src_a = id_in.ir[8:6];
        src_b = id_in.ir[2:0];
        case (opcode)
            lc3b_types::op_add, lc3b_types::op_and: begin
                use_a = 1'b1;
                use_b = ~id_in.ir[5];
            end
            lc3b_types::op_not, lc3b_types::op_ldr: begin
                use_a = 1'b1;
            end
            lc3b_types::op_str: begin
                use_a = 1'b1;
                use_b = 1'b1;
                src_b = id_in.ir[11:9];
            end
            default: begin
                use_a = 1'b0;
            end
        endcase
    end

    assign ex_wr  = ex_in.valid & ex_in.control.reg_write;
    assign mem_wr = mem_in.valid & mem_in.control.reg_write;

    // no forwarding, wait until the writer has retired
    assign decode_hold = id_in.valid &
                         (clash(use_a, src_a, ex_wr, ex_in.control.dest) |
                          clash(use_b, src_b, ex_wr, ex_in.control.dest) |
                          clash(use_a, src_a, mem_wr, mem_in.control.dest) |
                          clash(use_b, src_b, mem_wr, mem_in.control.dest));

    assign branch_in_flight = (id_in.valid & (opcode == lc3b_types::op_br)) |
                              (ex_in.valid & ex_in.control.is_branch) |
                              (mem_in.valid & mem_in.control.is_branch);

    assign fetch_hold = decode_hold | branch_in_flight;

endmodule : hazard_controller

// File: source/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic                 clk,
    input  logic                 rst_n,
    output lc3b_types::lc3b_word imem_addr,
    input  lc3b_types::lc3b_word imem_data,
    output lc3b_types::lc3b_word dmem_addr,
    output lc3b_types::lc3b_word dmem_wdata,
    output logic                 dmem_we,
    input  lc3b_types::lc3b_word dmem_rdata
);

    // stage outputs, each one is a pipeline barrier
    lc3b_types::if_id_t   if_id;
    lc3b_types::id_ex_t   id_ex;
    lc3b_types::ex_mem_t  ex_mem;
    lc3b_types::wb_t      wb;

    logic                 fetch_hold;
    logic                 decode_hold;
    logic                 redirect;
    lc3b_types::lc3b_word redirect_pc;

    hazard_controller i_hazard_controller (
        .id_in       (if_id),
        .ex_in       (id_ex),
        .mem_in      (ex_mem),
        .fetch_hold  (fetch_hold),
        .decode_hold (decode_hold)
    );

    stage_if i_stage_if (
        .clk,
        .rst_n,
        .fetch_hold,
        .decode_hold,
        .redirect,
        .redirect_pc,
        .imem_addr,
        .imem_data,
        .if_out      (if_id)
    );

    stage_id i_stage_id (
        .clk,
        .rst_n,
        .decode_hold,
        .id_in       (if_id),
        .wb_in       (wb),
        .id_out      (id_ex)
    );

    stage_ex i_stage_ex (
        .clk,
        .rst_n,
        .ex_in       (id_ex),
        .ex_out      (ex_mem)
    );

    // memory access and writeback share one stage
    stage_mem i_stage_mem (
        .clk,
        .rst_n,
        .mem_in      (ex_mem),
        .dmem_addr,
        .dmem_wdata,
        .dmem_we,
        .dmem_rdata,
        .redirect,
        .redirect_pc,
        .wb_out      (wb)
    );

endmodule : cpu

// File: testbench/tb_cpu.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module tb_cpu;

    localparam int NUM_TESTS  = 40;
    localparam int BODY_LEN   = 24;
    // body, eight tail stores and the self-loop
    localparam int PROG_LEN   = BODY_LEN + 8 + 1;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 1 << (`LC3B_WORD_W - 1);
    localparam int TIMEOUT_NS = NUM_TESTS * PROG_LEN * 8 * 8;

    logic                 clk;
    logic                 rst_n;
    lc3b_types::lc3b_word imem_addr;
    lc3b_types::lc3b_word imem_data;
    lc3b_types::lc3b_word dmem_addr;
    lc3b_types::lc3b_word dmem_wdata;
    logic                 dmem_we;
    lc3b_types::lc3b_word dmem_rdata;

    lc3b_types::lc3b_word imem [0:IMEM_WORDS-1];
    lc3b_types::lc3b_word dmem [0:DMEM_WORDS-1];

    // reference model state
    lc3b_types::lc3b_word mem_model [int];
    lc3b_types::lc3b_word exp_addr[$];
    lc3b_types::lc3b_word exp_data[$];
    lc3b_types::lc3b_word trace[$];
    lc3b_types::lc3b_word loop_pc;
    lc3b_types::lc3b_word last_addr;

    integer seed;
    int     test_num;
    int     store_idx;
    int     fetch_idx;
    int     store_errors;
    int     fetch_errors;
    int     other_errors;
    logic   running;

    cpu uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // both memories read combinationally
    assign imem_data  = imem[imem_addr[8:1]];
    assign dmem_rdata = dmem[dmem_addr[15:1]];

    always @(posedge clk) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[15:1]] <= dmem_wdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic lc3b_types::lc3b_word fill_word(input logic [14:0] idx);
        return {idx, 1'b0} ^ {1'b1, idx} ^ 16'h3c5a;
    endfunction

    function automatic lc3b_types::lc3b_word read_model(input lc3b_types::lc3b_word ea);
        if (mem_model.exists(ea[15:1])) begin
            return mem_model[ea[15:1]];
        end
        return fill_word(ea[15:1]);
    endfunction

    // consecutive repeats collapse, the DUT only shows address changes
    function automatic void push_fetch(input lc3b_types::lc3b_word addr);
        if (trace.size() == 0 || trace[$] != addr) begin
            trace.push_back(addr);
        end
    endfunction

    task automatic compare_store(input lc3b_types::lc3b_word addr,
                                 input lc3b_types::lc3b_word data);
        if (store_idx >= exp_addr.size()) begin
            other_errors++;
            $display("unexpected store of %h to %h at %0t in test %0d",
                     data, addr, $time, test_num);
        end else if (addr !== exp_addr[store_idx] || data !== exp_data[store_idx]) begin
            store_errors++;
            $display("Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                     $time, store_idx, data, addr, exp_data[store_idx], exp_addr[store_idx]);
        end
        store_idx++;
    endtask

    task automatic compare_fetch(input lc3b_types::lc3b_word addr);
        if (fetch_idx >= trace.size()) begin
            other_errors++;
            $display("fetch ran past the self-loop to %h at %0t", addr, $time);
        end else if (addr !== trace[fetch_idx]) begin
            fetch_errors++;
            $display("Error at %0t: fetch %0d from %h, expected %h",
                     $time, fetch_idx, addr, trace[fetch_idx]);
        end
        fetch_idx++;
    endtask

    task automatic build_program();
        int                   kind;
        int                   span;
        logic [3:0]           opc;
        lc3b_types::lc3b_reg  dr;
        lc3b_types::lc3b_reg  sa;
        lc3b_types::lc3b_reg  sb;
        lc3b_types::lc3b_reg  base;
        lc3b_types::lc3b_word ir;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = fill_word(15'(i));
        end
        for (int k = 0; k < BODY_LEN; k++) begin
            kind = pick(10);
            // r7 is never written and serves as a zero data pointer
            dr   = 3'(pick(7));
            sa   = 3'(pick(8));
            sb   = 3'(pick(8));
            base = (pick(4) == 0) ? sa : 3'd7;
            case (kind)
                0, 1, 2, 3: begin
                    opc = (kind < 2) ? lc3b_types::op_add : lc3b_types::op_and;
                    if (pick(2) == 1) begin
                        ir = {opc, dr, sa, 1'b1, 5'(pick(32))};
                    end else begin
                        ir = {opc, dr, sa, 3'b000, sb};
                    end
                end
                4: begin
                    opc = lc3b_types::op_not;
                    ir  = {opc, dr, sa, 6'b111111};
                end
                5, 6: begin
                    opc = lc3b_types::op_ldr;
                    ir  = {opc, dr, base, 6'(pick(64))};
                end
                7: begin
                    opc = lc3b_types::op_str;
                    ir  = {opc, sb, base, 6'(pick(64))};
                end
                default: begin
                    // forward only, never past the tail start
                    span = (BODY_LEN - k < 4) ? BODY_LEN - k : 4;
                    opc  = lc3b_types::op_br;
                    ir   = {opc, 3'(pick(8)), 9'(pick(span))};
                end
            endcase
            imem[k] = ir;
        end
        opc = lc3b_types::op_str;
        for (int r = 0; r < 8; r++) begin
            imem[BODY_LEN + r] = {opc, 3'(r), 3'd7, 6'(r)};
        end
        opc = lc3b_types::op_br;
        imem[BODY_LEN + 8] = {opc, 3'b111, 9'h1ff};
        loop_pc = lc3b_types::lc3b_word'((BODY_LEN + 8) * 2);
    endtask

    // sequential ISA execution of the loaded program
    task automatic run_model();
        lc3b_types::lc3b_word regs [`LC3B_NUM_REGS];
        lc3b_types::lc3b_cc   cc;
        lc3b_types::lc3b_word pc;
        lc3b_types::lc3b_word pc_next;
        lc3b_types::lc3b_word ir;
        lc3b_types::lc3b_word operand;
        lc3b_types::lc3b_word result;
        lc3b_types::lc3b_word ea;
        logic                 writes;
        mem_model.delete();
        exp_addr.delete();
        exp_data.delete();
        trace.delete();
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        cc = 3'b010;
        pc = `LC3B_RESET_PC;
        while (pc != loop_pc) begin
            push_fetch(pc);
            ir      = imem[pc[8:1]];
            pc_next = pc + 16'd2;
            writes  = 1'b0;
            ea      = regs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
            case (ir[15:12])
                lc3b_types::op_add, lc3b_types::op_and: begin
                    operand = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
                    if (ir[15:12] == lc3b_types::op_add) begin
                        result = regs[ir[8:6]] + operand;
                    end else begin
                        result = regs[ir[8:6]] & operand;
                    end
                    writes = 1'b1;
                end
                lc3b_types::op_not: begin
                    result = ~regs[ir[8:6]];
                    writes = 1'b1;
                end
                lc3b_types::op_ldr: begin
                    result = read_model(ea);
                    writes = 1'b1;
                end
                lc3b_types::op_str: begin
                    mem_model[ea[15:1]] = regs[ir[11:9]];
                    exp_addr.push_back(ea);
                    exp_data.push_back(regs[ir[11:9]]);
                end
                default: begin
                    // fetch waits on the next word until the branch resolves
                    push_fetch(pc_next);
                    if ((ir[11:9] & cc) != 3'b000) begin
                        pc_next = pc_next + {{6{ir[8]}}, ir[8:0], 1'b0};
                    end
                end
            endcase
            if (writes) begin
                regs[ir[11:9]] = result;
                cc = result[15] ? 3'b100 : ((result == '0) ? 3'b010 : 3'b001);
            end
            pc = pc_next;
        end
        push_fetch(loop_pc);
        push_fetch(loop_pc + 16'd2);
        push_fetch(loop_pc);
    endtask

    task automatic apply_reset();
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (dmem_we === 1'b1) begin
            compare_store(dmem_addr, dmem_wdata);
        end
        if (running && imem_addr !== last_addr) begin
            compare_fetch(imem_addr);
        end
        last_addr = imem_addr;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("processor stopped making progress, test %0d timed out at %0t",
                 test_num, $time);
        $display("errors: store %0d, fetch %0d, other %0d",
                 store_errors, fetch_errors, other_errors);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed         = 2;
        rst_n        = 1'b0;
        running      = 1'b0;
        last_addr    = '0;
        store_idx    = 0;
        fetch_idx    = 0;
        store_errors = 0;
        fetch_errors = 0;
        other_errors = 0;
        for (test_num = 0; test_num < NUM_TESTS; test_num++) begin
            build_program();
            run_model();
            store_idx = 0;
            fetch_idx = 0;
            apply_reset();
            // first fetch comes straight from the reset PC
            compare_fetch(imem_addr);
            running = 1'b1;
            wait (fetch_idx >= trace.size());
            @(posedge clk);
            #1;
            running = 1'b0;
            rst_n   = 1'b0;
            if (store_idx != exp_addr.size()) begin
                other_errors++;
                $display("test %0d finished after %0d of %0d expected stores",
                         test_num, store_idx, exp_addr.size());
            end
        end
        $display("errors: store %0d, fetch %0d, other %0d",
                 store_errors, fetch_errors, other_errors);
        if (store_errors + fetch_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_cpu

// File: src.f
+incdir+source
source/lc3b_types.sv
source/stage_if.sv
source/stage_id.sv
source/stage_ex.sv
source/stage_mem.sv
source/hazard_controller.sv
source/cpu.sv
testbench/tb_cpu.sv
